// ==== verilog/priv_pkg.sv ====
// ****************************************
// Shared types, CSR addresses and bit positions for the machine-mode
// privilege unit; import it in each module that needs these names
// ****************************************
`default_nettype none

package priv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [11:0]     csr_addr_t;

  // mcause layout
  typedef struct packed {
    logic        interrupt;
    logic [30:0] code;
  } cause_t;

  // Machine information registers
  localparam csr_addr_t MVENDORID_ADDR = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR   = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR    = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR   = 12'hF14;
  localparam csr_addr_t MISA_ADDR      = 12'h301;

  // Trap setup and handling
  localparam csr_addr_t MSTATUS_ADDR  = 12'h300;
  localparam csr_addr_t MEDELEG_ADDR  = 12'h302;
  localparam csr_addr_t MIDELEG_ADDR  = 12'h303;
  localparam csr_addr_t MIE_ADDR      = 12'h304;
  localparam csr_addr_t MTVEC_ADDR    = 12'h305;
  localparam csr_addr_t MSCRATCH_ADDR = 12'h340;
  localparam csr_addr_t MEPC_ADDR     = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR   = 12'h342;
  localparam csr_addr_t MTVAL_ADDR    = 12'h343;
  localparam csr_addr_t MIP_ADDR      = 12'h344;

  // Timer registers, older machine-mode map
  localparam csr_addr_t MTIMECMP_ADDR = 12'h321;
  localparam csr_addr_t MTIME_ADDR    = 12'h701;
  localparam csr_addr_t MTIMEH_ADDR   = 12'h741;

  // Counters
  localparam csr_addr_t MCYCLE_ADDR    = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR  = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR   = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR = 12'hB82;

  // MXL = 1 (RV32), extension I only
  localparam word_t MISA_VALUE = 32'h4000_0100;

  localparam logic [30:0] CAUSE_ILLEGAL = 31'd2;
  localparam logic [30:0] CAUSE_MSI     = 31'd3;
  localparam logic [30:0] CAUSE_MTI     = 31'd7;
  localparam logic [30:0] CAUSE_ECALL_M = 31'd11;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MIE_MSIE_BIT     = 3;
  localparam int MIE_MTIE_BIT     = 7;
  localparam int MIP_MSIP_BIT     = 3;
  localparam int MIP_MTIP_BIT     = 7;

  // Writable fields
  localparam word_t MSTATUS_WMASK = 32'h0000_0088;
  localparam word_t MIE_WMASK     = 32'h0000_0088;
  localparam word_t MTVEC_WMASK   = 32'hFFFF_FFFD;

  localparam logic [1:0] MTVEC_MODE_DIRECT   = 2'd0;
  localparam logic [1:0] MTVEC_MODE_VECTORED = 2'd1;

endpackage

`default_nettype wire

// ==== verilog/irq_prioritizer.sv ====
// ****************************************
// Picks the highest-priority enabled interrupt; MTI ranks above MSI
// ****************************************
`default_nettype none

module irq_prioritizer (
  input  wire priv_pkg::word_t mie_bits,
  input  wire priv_pkg::word_t mip_bits,
  input  wire logic            global_mie,
  output logic                 irq_take,
  output priv_pkg::cause_t     irq_cause,
  output priv_pkg::word_t      irq_offset
);
  import priv_pkg::*;

  word_t       active;
  logic [30:0] code;

  // Enable and pending bits share positions
  assign active = mie_bits & mip_bits & {XLEN{global_mie}};

  always_comb begin
    irq_take = 1'b1;
    if (active[MIP_MTIP_BIT]) begin
      code = CAUSE_MTI;
    end else if (active[MIP_MSIP_BIT]) begin
      code = CAUSE_MSI;
    end else begin
      irq_take = 1'b0;
      code     = '0;
    end
  end

  assign irq_cause.interrupt = irq_take;
  assign irq_cause.code      = code;

  // Vector table entries are one word apart
  assign irq_offset = {code[29:0], 2'b00};

endmodule

`default_nettype wire

// ==== verilog/machine_counters.sv ====
// ****************************************
// Prescaled 64-bit mtime with mtimecmp compare, and the cycle and
// instret counters; CSR writes arrive as strobes with merged data
// ****************************************
`default_nettype none

module machine_counters #(
  parameter int MTIME_PRESCALE = 1
) (
  input  wire logic            CLK,
  input  wire logic            nRST,
  input  wire logic            instr_retired,
  input  wire logic            time_lo_we,
  input  wire logic            time_hi_we,
  input  wire logic            cmp_we,
  input  wire priv_pkg::word_t wr_data,
  output priv_pkg::word_t      mtime,
  output priv_pkg::word_t      mtimeh,
  output priv_pkg::word_t      mtimecmp,
  output priv_pkg::word_t      cycle,
  output priv_pkg::word_t      cycleh,
  output priv_pkg::word_t      instret,
  output priv_pkg::word_t      instreth,
  output logic                 timer_pending
);
  import priv_pkg::*;

  localparam int PW = (MTIME_PRESCALE > 1) ? $clog2(MTIME_PRESCALE) : 1;

  logic [PW-1:0] pre_cnt;
  logic          tick;
  logic [63:0]   mtime_q;
  logic [63:0]   cycle_q;
  logic [63:0]   instret_q;
  word_t         cmp_q;

  assign tick = (pre_cnt == PW'(MTIME_PRESCALE - 1));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pre_cnt       <= '0;
      mtime_q       <= '0;
      cycle_q       <= '0;
      instret_q     <= '0;
      cmp_q         <= '0;
      timer_pending <= 1'b0;
    end else begin
      pre_cnt <= tick ? '0 : pre_cnt + 1'b1;

      // A CSR write replaces the increment for that cycle
      if (time_lo_we) begin
        mtime_q <= {mtime_q[63:32], wr_data};
      end else if (time_hi_we) begin
        mtime_q <= {wr_data, mtime_q[31:0]};
      end else if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end

      cycle_q <= cycle_q + 64'd1;
      if (instr_retired) instret_q <= instret_q + 64'd1;

      if (cmp_we) begin
        cmp_q         <= wr_data;
        timer_pending <= 1'b0;
      end else begin
        timer_pending <= (mtime_q >= {32'd0, cmp_q});
      end
    end
  end

  assign mtime    = mtime_q[31:0];
  assign mtimeh   = mtime_q[63:32];
  assign mtimecmp = cmp_q;
  assign cycle    = cycle_q[31:0];
  assign cycleh   = cycle_q[63:32];
  assign instret  = instret_q[31:0];
  assign instreth = instret_q[63:32];

  a_prescale: assert property (@(posedge CLK) MTIME_PRESCALE >= 1);

endmodule

`default_nettype wire

// ==== verilog/trap_ctrl.sv ====
// ****************************************
// Sequences trap entry and mret, and drives the fetch redirect
// ****************************************
`default_nettype none

module trap_ctrl (
  input  wire logic             CLK,
  input  wire logic             nRST,
  input  wire logic             exception,
  input  wire priv_pkg::cause_t ex_cause,
  input  wire priv_pkg::word_t  ex_pc,
  input  wire priv_pkg::word_t  ex_tval,
  input  wire logic             mret,
  input  wire priv_pkg::word_t  pipe_pc,
  input  wire logic             irq_take,
  input  wire priv_pkg::cause_t irq_cause,
  input  wire priv_pkg::word_t  irq_offset,
  input  wire priv_pkg::word_t  mtvec,
  input  wire priv_pkg::word_t  mepc,
  output logic                  trap_save,
  output priv_pkg::word_t       save_pc,
  output priv_pkg::cause_t      save_cause,
  output priv_pkg::word_t       save_tval,
  output logic                  restore,
  output logic                  redirect,
  output priv_pkg::word_t       redirect_pc
);
  import priv_pkg::*;

  typedef enum logic [1:0] {IDLE, SAVE, VECTOR, RETURN} state_t;

  state_t state;
  state_t state_next;
  word_t  offset_q;
  word_t  base;
  logic   accept_ex;
  logic   accept_irq;

  assign accept_ex  = (state == IDLE) && exception;
  assign accept_irq = (state == IDLE) && !exception && !mret && irq_take;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (exception || irq_take) state_next = SAVE;
        if (mret)                  state_next = RETURN;
      end
      SAVE:    state_next = VECTOR;
      VECTOR:  state_next = IDLE;
      RETURN:  state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Event payload, exception first
  always_ff @(posedge CLK) begin
    if (accept_ex) begin
      save_pc    <= ex_pc;
      save_cause <= ex_cause;
      save_tval  <= ex_tval;
      offset_q   <= '0;
    end else if (accept_irq) begin
      save_pc    <= pipe_pc;
      save_cause <= irq_cause;
      save_tval  <= '0;
      offset_q   <= irq_offset;
    end
  end

  assign base = {mtvec[31:2], 2'b00};

  assign trap_save = (state == SAVE);
  assign restore   = (state == RETURN);
  assign redirect  = (state == VECTOR) || (state == RETURN);

  // Only interrupts use the vector table
  always_comb begin
    if (state == RETURN) begin
      redirect_pc = mepc;
    end else if (mtvec[1:0] == MTVEC_MODE_VECTORED && save_cause.interrupt) begin
      redirect_pc = base + offset_q;
    end else begin
      redirect_pc = base;
    end
  end

  // No new trap or return strobe while one is in flight
  a_idle_strobes: assert property (@(posedge CLK) disable iff (!nRST)
    (state != IDLE) |-> !(exception || mret));

  a_ex_mret_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(exception && mret));

endmodule

`default_nettype wire

// ==== verilog/csr_rfile.sv ====
// ****************************************
// Machine CSR storage with swap/set/clear access from the pipeline
// and trap-side updates from the trap controller
// ****************************************
`default_nettype none

module csr_rfile (
  input  wire logic                CLK,
  input  wire logic                nRST,
  input  wire priv_pkg::csr_addr_t csr_addr,
  input  wire priv_pkg::word_t     csr_wdata,
  input  wire logic                csr_swap,
  input  wire logic                csr_set,
  input  wire logic                csr_clr,
  output priv_pkg::word_t          csr_rdata,
  output logic                     csr_invalid,
  input  wire logic                soft_irq,
  input  wire logic                trap_save,
  input  wire priv_pkg::word_t     save_pc,
  input  wire priv_pkg::cause_t    save_cause,
  input  wire priv_pkg::word_t     save_tval,
  input  wire logic                restore,
  input  wire priv_pkg::word_t     mtime,
  input  wire priv_pkg::word_t     mtimeh,
  input  wire priv_pkg::word_t     mtimecmp,
  input  wire priv_pkg::word_t     cycle,
  input  wire priv_pkg::word_t     cycleh,
  input  wire priv_pkg::word_t     instret,
  input  wire priv_pkg::word_t     instreth,
  input  wire logic                timer_pending,
  output logic                     time_lo_we,
  output logic                     time_hi_we,
  output logic                     cmp_we,
  output priv_pkg::word_t          wr_data,
  output priv_pkg::word_t          mtvec,
  output priv_pkg::word_t          mepc,
  output priv_pkg::word_t          mie_bits,
  output priv_pkg::word_t          mip_bits,
  output logic                     global_mie
);
  import priv_pkg::*;

  word_t  mstatus_q;
  word_t  mie_q;
  word_t  mtvec_q;
  word_t  mscratch_q;
  word_t  mepc_q;
  cause_t mcause_q;
  word_t  mtval_q;
  word_t  mip_val;
  logic   csr_op;
  logic   addr_valid;
  logic   wr_en;

  // Pending bits come straight from their sources
  always_comb begin
    mip_val = '0;
    mip_val[MIP_MTIP_BIT] = timer_pending;
    mip_val[MIP_MSIP_BIT] = soft_irq;
  end

  always_comb begin
    addr_valid = 1'b1;
    case (csr_addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MHARTID_ADDR: csr_rdata = '0;
      MISA_ADDR:      csr_rdata = MISA_VALUE;
      MSTATUS_ADDR:   csr_rdata = mstatus_q;
      MEDELEG_ADDR:   csr_rdata = '0;
      MIDELEG_ADDR:   csr_rdata = '0;
      MIE_ADDR:       csr_rdata = mie_q;
      MTVEC_ADDR:     csr_rdata = mtvec_q;
      MSCRATCH_ADDR:  csr_rdata = mscratch_q;
      MEPC_ADDR:      csr_rdata = mepc_q;
      MCAUSE_ADDR:    csr_rdata = mcause_q;
      MTVAL_ADDR:     csr_rdata = mtval_q;
      MIP_ADDR:       csr_rdata = mip_val;
      MTIMECMP_ADDR:  csr_rdata = mtimecmp;
      MTIME_ADDR:     csr_rdata = mtime;
      MTIMEH_ADDR:    csr_rdata = mtimeh;
      MCYCLE_ADDR:    csr_rdata = cycle;
      MCYCLEH_ADDR:   csr_rdata = cycleh;
      MINSTRET_ADDR:  csr_rdata = instret;
      MINSTRETH_ADDR: csr_rdata = instreth;
      default: begin
        addr_valid = 1'b0;
        csr_rdata  = '0;
      end
    endcase
  end

  assign csr_op      = csr_swap | csr_set | csr_clr;
  assign csr_invalid = csr_op & ~addr_valid;
  assign wr_en       = csr_op & addr_valid;

  // Merge against the old value
  assign wr_data = csr_swap ? csr_wdata :
                   csr_set  ? (csr_rdata | csr_wdata) :
                              (csr_rdata & ~csr_wdata);

  // Timer writes are applied inside the counter block
  assign time_lo_we = wr_en && (csr_addr == MTIME_ADDR);
  assign time_hi_we = wr_en && (csr_addr == MTIMEH_ADDR);
  assign cmp_we     = wr_en && (csr_addr == MTIMECMP_ADDR);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_q  <= '0;
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else begin
      // Trap entry and return win over a pipeline write
      if (trap_save) begin
        mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
        mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;
      end else if (restore) begin
        mstatus_q[MSTATUS_MIE_BIT]  <= mstatus_q[MSTATUS_MPIE_BIT];
        mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
      end else if (wr_en && csr_addr == MSTATUS_ADDR) begin
        mstatus_q <= wr_data & MSTATUS_WMASK;
      end

      if (trap_save) begin
        mepc_q   <= save_pc;
        mcause_q <= save_cause;
        mtval_q  <= save_tval;
      end else if (wr_en) begin
        case (csr_addr)
          MEPC_ADDR:   mepc_q   <= wr_data;
          MCAUSE_ADDR: mcause_q <= cause_t'(wr_data);
          MTVAL_ADDR:  mtval_q  <= wr_data;
          default:     ;
        endcase
      end

      if (wr_en) begin
        case (csr_addr)
          MIE_ADDR:      mie_q      <= wr_data & MIE_WMASK;
          MTVEC_ADDR:    mtvec_q    <= wr_data & MTVEC_WMASK;
          MSCRATCH_ADDR: mscratch_q <= wr_data;
          default:       ;
        endcase
      end
    end
  end

  assign mtvec      = mtvec_q;
  assign mepc       = mepc_q;
  assign mie_bits   = mie_q;
  assign mip_bits   = mip_val;
  assign global_mie = mstatus_q[MSTATUS_MIE_BIT];

  // The pipeline issues at most one access per cycle
  a_one_op: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({csr_swap, csr_set, csr_clr}));

  // Trap entry and return never overlap
  a_save_restore_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(trap_save && restore));

endmodule

`default_nettype wire

// ==== verilog/priv_unit.sv ====
// ****************************************
// Machine-mode privilege unit top; set MTIME_PRESCALE to the number
// of clock cycles per mtime tick
// ****************************************
`default_nettype none

module priv_unit #(
  parameter int MTIME_PRESCALE = 1
) (
  input  wire logic                CLK,
  input  wire logic                nRST,
  input  wire priv_pkg::csr_addr_t csr_addr,
  input  wire priv_pkg::word_t     csr_wdata,
  input  wire logic                csr_swap,
  input  wire logic                csr_set,
  input  wire logic                csr_clr,
  output priv_pkg::word_t          csr_rdata,
  output logic                     csr_invalid,
  input  wire logic                exception,
  input  wire priv_pkg::cause_t    ex_cause,
  input  wire priv_pkg::word_t     ex_pc,
  input  wire priv_pkg::word_t     ex_tval,
  input  wire logic                mret,
  input  wire logic                instr_retired,
  input  wire priv_pkg::word_t     pipe_pc,
  input  wire logic                soft_irq,
  output logic                     redirect,
  output priv_pkg::word_t          redirect_pc
);
  import priv_pkg::*;

  logic   trap_save;
  logic   restore;
  word_t  save_pc;
  word_t  save_tval;
  cause_t save_cause;
  word_t  mtvec;
  word_t  mepc;
  word_t  mie_bits;
  word_t  mip_bits;
  logic   global_mie;
  logic   irq_take;
  cause_t irq_cause;
  word_t  irq_offset;
  word_t  mtime;
  word_t  mtimeh;
  word_t  mtimecmp;
  word_t  cycle;
  word_t  cycleh;
  word_t  instret;
  word_t  instreth;
  logic   timer_pending;
  logic   time_lo_we;
  logic   time_hi_we;
  logic   cmp_we;
  word_t  wr_data;

  csr_rfile u_csr_rfile (.*);

  trap_ctrl u_trap_ctrl (.*);

  machine_counters #(
    .MTIME_PRESCALE(MTIME_PRESCALE)
  ) u_counters (.*);

  irq_prioritizer u_irq_prio (.*);

endmodule

`default_nettype wire

// ==== verification/tb_priv_unit.sv ====
// ****************************************
// Directed testbench for the privilege unit; runs the CSR, trap,
// interrupt and counter tests and prints a summary at the end
// ****************************************
`default_nettype none

module tb_priv_unit;
  timeunit 1ns;
  timeprecision 1ps;

  import priv_pkg::*;

  localparam int    MAX_CYCLES    = 2000;
  localparam int    WINDOW        = 25;
  localparam int    OP_READ       = 0;
  localparam int    OP_SWAP       = 1;
  localparam int    OP_SET        = 2;
  localparam int    OP_CLR        = 3;
  localparam word_t ST_MIE        = 32'h1 << MSTATUS_MIE_BIT;
  localparam word_t ST_MPIE       = 32'h1 << MSTATUS_MPIE_BIT;
  localparam word_t IE_MSIE       = 32'h1 << MIE_MSIE_BIT;
  localparam word_t IE_MTIE       = 32'h1 << MIE_MTIE_BIT;
  localparam word_t IP_MTIP       = 32'h1 << MIP_MTIP_BIT;
  localparam word_t TVEC_DIRECT   = 32'h0000_1000;
  localparam word_t TVEC_VEC_BASE = 32'h0000_2000;
  localparam word_t FAR_CMP       = 32'hFFFF_0000;

  logic      CLK;
  logic      nRST;
  csr_addr_t csr_addr;
  word_t     csr_wdata;
  logic      csr_swap;
  logic      csr_set;
  logic      csr_clr;
  word_t     csr_rdata;
  logic      csr_invalid;
  logic      exception;
  cause_t    ex_cause;
  word_t     ex_pc;
  word_t     ex_tval;
  logic      mret;
  logic      instr_retired;
  word_t     pipe_pc;
  logic      soft_irq;
  logic      redirect;
  word_t     redirect_pc;

  logic [31:0] lfsr = 32'h5acc;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          cycles = 0;

  priv_unit #(
    .MTIME_PRESCALE(4)
  ) DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Run limit, well above the length of all tests
  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic word_t rand_word();
    word_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  task automatic check(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    $display("%-20s %0d error(s)", name, errors - err_before);
  endtask

  // One CSR cycle; entered and left 2 ns after a rising edge
  task automatic csr_access(input int kind, input csr_addr_t addr, input word_t wdata,
                            output word_t old, output logic inv);
    csr_addr  = addr;
    csr_wdata = wdata;
    csr_swap  = (kind == OP_SWAP);
    csr_set   = (kind == OP_SET);
    csr_clr   = (kind == OP_CLR);
    @(negedge CLK);
    old = csr_rdata;
    inv = csr_invalid;
    @(posedge CLK);
    #2;
    csr_swap = 1'b0;
    csr_set  = 1'b0;
    csr_clr  = 1'b0;
  endtask

  task automatic csr_read(input csr_addr_t addr, output word_t val);
    logic inv;
    csr_access(OP_READ, addr, '0, val, inv);
  endtask

  task automatic csr_write(input int kind, input csr_addr_t addr, input word_t wdata);
    word_t old;
    logic  inv;
    csr_access(kind, addr, wdata, old, inv);
  endtask

  task automatic pulse_mret();
    mret = 1'b1;
    @(posedge CLK);
    #2;
    mret = 1'b0;
  endtask

  // Edges are counted from start; lat is -1 when nothing arrives
  task automatic wait_redirect(input int start, input int limit,
                               output int lat, output word_t tgt);
    logic seen;
    seen = 1'b0;
    lat  = start;
    tgt  = '0;
    while (!seen && lat <= limit) begin
      @(negedge CLK);
      if (redirect) begin
        seen = 1'b1;
        tgt  = redirect_pc;
      end else begin
        lat++;
      end
      @(posedge CLK);
      #2;
    end
    if (!seen) begin
      errors++;
      lat = -1;
      $display("no redirect seen within %0d cycles", limit);
    end
  endtask

  task automatic reset_values();
    int    err0;
    word_t val;
    logic  inv;
    err0 = errors;
    csr_read(MISA_ADDR, val);
    check("misa", val, MISA_VALUE);
    csr_read(MVENDORID_ADDR, val);
    check("mvendorid", val, '0);
    csr_read(MARCHID_ADDR, val);
    check("marchid", val, '0);
    csr_read(MIMPID_ADDR, val);
    check("mimpid", val, '0);
    csr_read(MHARTID_ADDR, val);
    check("mhartid", val, '0);
    csr_read(MSTATUS_ADDR, val);
    check("mstatus", val, '0);
    csr_read(MIE_ADDR, val);
    check("mie", val, '0);
    csr_read(MEPC_ADDR, val);
    check("mepc", val, '0);
    // 0x7c0 is not implemented
    csr_access(OP_SET, 12'h7C0, '0, val, inv);
    check("csr_invalid 0x7c0", 32'(inv), 32'h1);
    csr_access(OP_SET, MEDELEG_ADDR, '0, val, inv);
    check("medeleg", val, '0);
    check("csr_invalid medeleg", 32'(inv), 32'h0);
    csr_access(OP_SET, MIDELEG_ADDR, '0, val, inv);
    check("mideleg", val, '0);
    check("csr_invalid mideleg", 32'(inv), 32'h0);
    report_test("reset_values", err0);
  endtask

  task automatic csr_operations();
    int    err0;
    word_t val;
    word_t model;
    word_t data;
    logic  inv;
    err0  = errors;
    model = '0;
    data  = rand_word();
    csr_access(OP_SWAP, MSCRATCH_ADDR, data, val, inv);
    check("mscratch old on swap", val, model);
    model = data;
    data  = rand_word();
    csr_access(OP_SET, MSCRATCH_ADDR, data, val, inv);
    check("mscratch old on set", val, model);
    model = model | data;
    data  = rand_word();
    csr_access(OP_CLR, MSCRATCH_ADDR, data, val, inv);
    check("mscratch old on clear", val, model);
    model = model & ~data;
    csr_read(MSCRATCH_ADDR, val);
    check("mscratch", val, model);
    // Only MIE and MPIE stick
    csr_write(OP_SWAP, MSTATUS_ADDR, 32'hFFFF_FFFF);
    csr_read(MSTATUS_ADDR, val);
    check("mstatus", val, ST_MIE | ST_MPIE);
    csr_write(OP_SWAP, MSTATUS_ADDR, '0);
    report_test("csr_operations", err0);
  endtask

  task automatic exception_and_mret();
    int    err0;
    int    lat;
    word_t val;
    word_t tgt;
    word_t pc;
    word_t tval;
    err0 = errors;
    csr_write(OP_SWAP, MTVEC_ADDR, TVEC_DIRECT);
    csr_write(OP_SET, MSTATUS_ADDR, ST_MIE);
    pc        = rand_word() & ~32'h3;
    tval      = rand_word();
    exception = 1'b1;
    ex_cause  = {1'b0, CAUSE_ECALL_M};
    ex_pc     = pc;
    ex_tval   = tval;
    @(posedge CLK);
    #2;
    exception = 1'b0;
    wait_redirect(1, 10, lat, tgt);
    check("exception redirect latency", 32'(lat), 32'd2);
    check("redirect_pc", tgt, TVEC_DIRECT);
    csr_read(MEPC_ADDR, val);
    check("mepc", val, pc);
    csr_read(MCAUSE_ADDR, val);
    check("mcause", val, {1'b0, CAUSE_ECALL_M});
    csr_read(MTVAL_ADDR, val);
    check("mtval", val, tval);
    csr_read(MSTATUS_ADDR, val);
    check("mstatus after trap", val, ST_MPIE);
    pulse_mret();
    wait_redirect(1, 10, lat, tgt);
    check("mret redirect latency", 32'(lat), 32'd1);
    check("redirect_pc", tgt, pc);
    csr_read(MSTATUS_ADDR, val);
    check("mstatus after mret", val, ST_MIE | ST_MPIE);
    report_test("exception_and_mret", err0);
  endtask

  task automatic timer_interrupt();
    int    err0;
    int    lat;
    word_t val;
    word_t tgt;
    err0 = errors;
    csr_write(OP_CLR, MSTATUS_ADDR, ST_MIE);
    csr_write(OP_SWAP, MTVEC_ADDR, TVEC_VEC_BASE | 32'(MTVEC_MODE_VECTORED));
    csr_write(OP_SWAP, MTIME_ADDR, '0);
    csr_write(OP_SWAP, MTIMECMP_ADDR, 32'd40);
    csr_write(OP_SET, MIE_ADDR, IE_MTIE);
    pipe_pc = rand_word() & ~32'h3;
    csr_write(OP_SET, MSTATUS_ADDR, ST_MIE);
    // mtime ticks once per 4 cycles
    wait_redirect(0, 4 * 40 + 40, lat, tgt);
    check("timer redirect_pc", tgt, TVEC_VEC_BASE + (32'(CAUSE_MTI) << 2));
    csr_read(MCAUSE_ADDR, val);
    check("mcause", val, {1'b1, CAUSE_MTI});
    csr_read(MEPC_ADDR, val);
    check("mepc", val, pipe_pc);
    csr_read(MTIME_ADDR, val);
    check("mtime reached mtimecmp", 32'(val >= 32'd40), 32'h1);
    csr_read(MIP_ADDR, val);
    check("mip MTIP before rearm", val & IP_MTIP, IP_MTIP);
    csr_write(OP_SWAP, MTIMECMP_ADDR, FAR_CMP);
    csr_read(MIP_ADDR, val);
    check("mip MTIP after rearm", val & IP_MTIP, '0);
    pulse_mret();
    wait_redirect(1, 10, lat, tgt);
    check("mret redirect_pc", tgt, pipe_pc);
    report_test("timer_interrupt", err0);
  endtask

  task automatic interrupt_priority();
    int    err0;
    int    lat;
    word_t val;
    word_t tgt;
    err0 = errors;
    csr_write(OP_CLR, MSTATUS_ADDR, ST_MIE);
    soft_irq = 1'b1;
    csr_write(OP_SWAP, MTIMECMP_ADDR, '0);
    csr_write(OP_SET, MIE_ADDR, IE_MSIE);
    pipe_pc = rand_word() & ~32'h3;
    csr_write(OP_SET, MSTATUS_ADDR, ST_MIE);
    wait_redirect(0, 20, lat, tgt);
    check("first redirect_pc", tgt, TVEC_VEC_BASE + (32'(CAUSE_MTI) << 2));
    csr_read(MCAUSE_ADDR, val);
    check("first mcause", val, {1'b1, CAUSE_MTI});
    csr_write(OP_SWAP, MTIMECMP_ADDR, FAR_CMP);
    pulse_mret();
    wait_redirect(1, 10, lat, tgt);
    check("mret redirect_pc", tgt, pipe_pc);
    // MIE comes back on and MSIP is still raised
    wait_redirect(0, 20, lat, tgt);
    check("second redirect_pc", tgt, TVEC_VEC_BASE + (32'(CAUSE_MSI) << 2));
    csr_read(MCAUSE_ADDR, val);
    check("second mcause", val, {1'b1, CAUSE_MSI});
    soft_irq = 1'b0;
    pulse_mret();
    wait_redirect(1, 10, lat, tgt);
    check("second mret redirect_pc", tgt, pipe_pc);
    report_test("interrupt_priority", err0);
  endtask

  task automatic counter_checks();
    int    err0;
    int    ones;
    word_t c0;
    word_t c1;
    word_t i0;
    word_t i1;
    word_t hi;
    word_t lo;
    word_t val;
    err0 = errors;
    ones = 0;
    csr_write(OP_CLR, MSTATUS_ADDR, ST_MIE);
    csr_read(MINSTRET_ADDR, i0);
    csr_read(MCYCLE_ADDR, c0);
    for (int k = 0; k < WINDOW; k++) begin
      instr_retired = lfsr_bit();
      if (instr_retired) ones++;
      @(posedge CLK);
      #2;
    end
    instr_retired = 1'b0;
    csr_read(MCYCLE_ADDR, c1);
    csr_read(MINSTRET_ADDR, i1);
    // One extra cycle for the read before the window
    check("mcycle delta", c1 - c0, 32'(WINDOW + 1));
    check("minstret delta", i1 - i0, 32'(ones));
    hi = rand_word();
    lo = rand_word() & 32'h0FFF_FFFF;
    csr_write(OP_SWAP, MTIMEH_ADDR, hi);
    csr_write(OP_SWAP, MTIME_ADDR, lo);
    csr_read(MTIME_ADDR, val);
    // At most one prescaled tick past the written value
    check("mtime within one tick", 32'((val - lo) <= 32'd1), 32'h1);
    csr_read(MTIMEH_ADDR, val);
    check("mtimeh", val, hi);
    report_test("counter_checks", err0);
  endtask

  initial begin
    nRST          = 1'b0;
    csr_addr      = '0;
    csr_wdata     = '0;
    csr_swap      = 1'b0;
    csr_set       = 1'b0;
    csr_clr       = 1'b0;
    exception     = 1'b0;
    ex_cause      = '0;
    ex_pc         = '0;
    ex_tval       = '0;
    mret          = 1'b0;
    instr_retired = 1'b0;
    pipe_pc       = '0;
    soft_irq      = 1'b0;
    repeat (10) @(posedge CLK);
    #2;
    nRST = 1'b1;
    @(posedge CLK);
    #2;
    reset_values();
    csr_operations();
    exception_and_mret();
    timer_interrupt();
    interrupt_priority();
    counter_checks();
    $display("tests=%0d checks=%0d errors=%0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/priv_pkg.sv
verilog/irq_prioritizer.sv
verilog/machine_counters.sv
verilog/trap_ctrl.sv
verilog/csr_rfile.sv
verilog/priv_unit.sv
verification/tb_priv_unit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_priv_unit
FILELIST  = project.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)
